//--- design/qspi_pkg.sv
//////////////////////////////////////////////////
// QSPI memory slave shared definitions
// Command codes, phase lengths, memory geometry
// and the phase encodings of the frame decoder
//////////////////////////////////////////////////

`default_nettype none

package qspi_pkg;

  // Command codes, first byte of every frame
  localparam logic [7:0] CMD_STATUS = 8'h01;  // Status byte follows
  localparam logic [7:0] CMD_WRITE  = 8'h02;  // Address, then data words
  localparam logic [7:0] CMD_READ   = 8'h0B;  // Address, dummy, then data out

  // Phase lengths
  localparam int DUMMY_CYCLES = 32;  // Idle clocks between read address and data
  localparam int DUMMY_CNT_W  = $clog2(DUMMY_CYCLES + 1);
  localparam int ADDR_BYTES   = 4;

  // Memory geometry, word index from address bits 9..2
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;

  localparam int STATUS_QUAD_BIT = 0;  // Quad enable position in status byte

  // Frame decoder phases
  localparam logic [2:0] ST_IDLE   = 3'd0;  // Chip select high
  localparam logic [2:0] ST_CMD    = 3'd1;
  localparam logic [2:0] ST_STATUS = 3'd2;
  localparam logic [2:0] ST_ADDR   = 3'd3;
  localparam logic [2:0] ST_WDATA  = 3'd4;
  localparam logic [2:0] ST_DUMMY  = 3'd5;
  localparam logic [2:0] ST_RDATA  = 3'd6;
  localparam logic [2:0] ST_IGNORE = 3'd7;  // Rest of frame dropped

endpackage

`default_nettype wire

//--- design/qspi_rx.sv
//////////////////////////////////////////////////
// QSPI slave receive side
// Shifts lane 0 or all four lanes into a 32-bit
// history and flags every completed byte
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qspi_rx (
  input  wire logic        spis_sck_i,
  input  wire logic        rst_i,
  input  wire logic        spis_csb_i,
  input  wire logic [3:0]  spis_sd_i,
  input  wire logic        quad_en_i,
  output logic      [7:0]  rx_byte_o,
  output logic             rx_byte_vld_o,
  output logic      [31:0] rx_word_o
);

  logic [2:0]  bit_cnt_q;   // Bits of the current byte already taken
  logic [2:0]  bit_step;
  logic [2:0]  bit_cnt_nxt;
  logic        vld_q;
  logic [31:0] hist_q;      // Last 32 bits received, newest at the bottom

  // Four bits per clock in quad mode, one otherwise
  assign bit_step    = quad_en_i ? 3'd4 : 3'd1;
  assign bit_cnt_nxt = bit_cnt_q + bit_step;

  // Byte counter, restarts at every frame
  always_ff @(posedge spis_sck_i) begin
    if (rst_i || spis_csb_i) begin
      bit_cnt_q <= 3'd0;
      vld_q     <= 1'b0;
    end else begin
      bit_cnt_q <= bit_cnt_nxt;
      vld_q     <= (bit_cnt_nxt == 3'd0);  // Wrap means byte complete
    end
  end

  // History shift register, MSB first on the wire
  always_ff @(posedge spis_sck_i) begin
    if (!spis_csb_i) begin
      if (quad_en_i) begin
        hist_q <= {hist_q[27:0], spis_sd_i};
      end else begin
        hist_q <= {hist_q[30:0], spis_sd_i[0]};  // MOSI on lane 0
      end
    end
  end

  // Completed byte sits in the low 8 bits while vld is high
  assign rx_byte_o     = hist_q[7:0];
  assign rx_byte_vld_o = vld_q;
  assign rx_word_o     = hist_q;

endmodule

`default_nettype wire

//--- design/qspi_cmd_ctrl.sv
//////////////////////////////////////////////////
// QSPI slave frame decoder
// Walks command, status, address, dummy and data
// phases, holds the quad mode bit and drives the
// memory ports and the transmit load strobes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qspi_cmd_ctrl import qspi_pkg::*; (
  input  wire logic              spis_sck_i,
  input  wire logic              rst_i,
  input  wire logic              spis_csb_i,
  input  wire logic [7:0]        rx_byte_i,
  input  wire logic              rx_byte_vld_i,
  input  wire logic [31:0]       rx_word_i,
  output logic                   quad_en_o,
  output logic                   mem_we_o,
  output logic      [MEM_AW-1:0] mem_waddr_o,
  output logic      [31:0]       mem_wdata_o,
  output logic                   mem_re_o,
  output logic      [MEM_AW-1:0] mem_raddr_o,
  output logic                   tx_load_o,
  output logic                   tx_active_o
);

  logic [2:0]             state_q;
  logic                   quad_q;      // Status register bit
  logic                   is_write_q;  // Command after the address phase
  logic [1:0]             byte_cnt_q;  // Byte within address or data word
  logic [DUMMY_CNT_W-1:0] cyc_cnt_q;   // Dummy clocks, then nibbles of a word
  logic                   re_q;
  logic                   load_q;
  logic [MEM_AW-1:0]      addr_q;      // Running word index
  logic                   addr_last;

  // Last address byte is in the history
  assign addr_last = (state_q == ST_ADDR) && rx_byte_vld_i &&
                     (byte_cnt_q == 2'(ADDR_BYTES - 1));

  always_ff @(posedge spis_sck_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      quad_q     <= 1'b0;  // Single lane after reset
      is_write_q <= 1'b0;
      byte_cnt_q <= 2'd0;
      cyc_cnt_q  <= '0;
      re_q       <= 1'b0;
      load_q     <= 1'b0;
    end else if (spis_csb_i) begin
      // End of frame, quad mode survives
      state_q    <= ST_IDLE;
      byte_cnt_q <= 2'd0;
      cyc_cnt_q  <= '0;
      re_q       <= 1'b0;
      load_q     <= 1'b0;
    end else begin
      re_q   <= 1'b0;  // Strobes last one clock
      load_q <= 1'b0;
      case (state_q)
        ST_IDLE: state_q <= ST_CMD;  // First edge with chip select low
        ST_CMD: begin
          if (rx_byte_vld_i) begin
            if (rx_byte_i == CMD_STATUS) begin
              state_q <= ST_STATUS;
            end else if (quad_q && ((rx_byte_i == CMD_WRITE) || (rx_byte_i == CMD_READ))) begin
              state_q    <= ST_ADDR;
              is_write_q <= (rx_byte_i == CMD_WRITE);
            end else begin
              state_q <= ST_IGNORE;  // Unknown, or memory access in single mode
            end
          end
        end
        ST_STATUS: begin
          if (rx_byte_vld_i) begin
            quad_q  <= rx_byte_i[STATUS_QUAD_BIT];
            state_q <= ST_IGNORE;
          end
        end
        ST_ADDR: begin
          if (rx_byte_vld_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
          end
          if (addr_last) begin
            byte_cnt_q <= 2'd0;
            if (is_write_q) begin
              state_q <= ST_WDATA;
            end else begin
              state_q   <= ST_DUMMY;
              re_q      <= 1'b1;  // Fetch first word during the dummy phase
              cyc_cnt_q <= DUMMY_CNT_W'(1);  // This edge is dummy clock 1
            end
          end
        end
        ST_WDATA: begin
          if (rx_byte_vld_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;  // Wraps every word
          end
        end
        ST_DUMMY: begin
          cyc_cnt_q <= cyc_cnt_q + 1'b1;
          // Load on the last dummy edge so nibble 0 follows it
          if (cyc_cnt_q == DUMMY_CNT_W'(DUMMY_CYCLES - 2)) begin
            state_q   <= ST_RDATA;
            cyc_cnt_q <= '0;
            load_q    <= 1'b1;
            re_q      <= 1'b1;  // Prefetch the next word
          end
        end
        ST_RDATA: begin
          cyc_cnt_q <= cyc_cnt_q + 1'b1;
          if (cyc_cnt_q[2:0] == 3'd7) begin  // Eight nibbles per word
            load_q <= 1'b1;
            re_q   <= 1'b1;
          end
        end
        default: ;  // ST_IGNORE waits for chip select
      endcase
    end
  end

  // Word index, bumped by every write and every read issued
  always_ff @(posedge spis_sck_i) begin
    if (addr_last) begin
      addr_q <= rx_word_i[MEM_AW+1:2];  // Higher address bits ignored
    end else if (mem_we_o || re_q) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // Write on the edge after the fourth data byte
  assign mem_we_o    = (state_q == ST_WDATA) && rx_byte_vld_i && (byte_cnt_q == 2'd3);
  assign mem_waddr_o = addr_q;
  assign mem_wdata_o = rx_word_i;
  assign mem_re_o    = re_q;
  assign mem_raddr_o = addr_q;

  assign quad_en_o   = quad_q;
  assign tx_load_o   = load_q;
  assign tx_active_o = (state_q == ST_RDATA) && !spis_csb_i;  // Drops on the CSB edge

endmodule

`default_nettype wire

//--- design/qspi_mem.sv
//////////////////////////////////////////////////
// QSPI slave word memory
// Synchronous write, registered read port
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qspi_mem import qspi_pkg::*; (
  input  wire logic              spis_sck_i,
  input  wire logic              we_i,
  input  wire logic [MEM_AW-1:0] waddr_i,
  input  wire logic [31:0]       wdata_i,
  input  wire logic              re_i,
  input  wire logic [MEM_AW-1:0] raddr_i,
  output logic      [31:0]       rdata_o
);

  logic [31:0] mem_q [MEM_WORDS];

  always_ff @(posedge spis_sck_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
    if (re_i) begin
      rdata_o <= mem_q[raddr_i];  // Held until the next read
    end
  end

endmodule

`default_nettype wire

//--- design/qspi_tx.sv
//////////////////////////////////////////////////
// QSPI slave transmit side
// Serializes read words MSB first, one nibble
// per clock, with a registered output enable
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qspi_tx (
  input  wire logic        spis_sck_i,
  input  wire logic        rst_i,
  input  wire logic        load_i,
  input  wire logic [31:0] word_i,
  input  wire logic        active_i,
  output logic      [3:0]  spis_sd_o,
  output logic             spis_oe_o
);

  logic [31:0] shift_q;  // Top nibble is on the lanes
  logic        oe_q;

  // Load a fresh word, otherwise move the next nibble up
  always_ff @(posedge spis_sck_i) begin
    if (load_i) begin
      shift_q <= word_i;
    end else begin
      shift_q <= {shift_q[27:0], 4'h0};
    end
  end

  // Enable follows the read data phase one edge later
  always_ff @(posedge spis_sck_i) begin
    if (rst_i) begin
      oe_q <= 1'b0;
    end else begin
      oe_q <= active_i;
    end
  end

  assign spis_sd_o = shift_q[31:28];
  assign spis_oe_o = oe_q;

endmodule

`default_nettype wire

//--- design/qspi_slave_top.sv
//////////////////////////////////////////////////
// QSPI memory access slave
// Receive side, frame decoder, word memory and
// transmit side on the serial clock
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qspi_slave_top import qspi_pkg::*; (
  input  wire logic       spis_sck_i,
  input  wire logic       rst_i,
  input  wire logic       spis_csb_i,   // Active low frame
  input  wire logic [3:0] spis_sd_i,
  output logic      [3:0] spis_sd_o,
  output logic            spis_oe_o,    // Testbench drives the bus when low
  output logic            quad_en_o
);

  logic [7:0]        rx_byte;
  logic              rx_byte_vld;
  logic [31:0]       rx_word;
  logic              quad_en;
  logic              mem_we;
  logic [MEM_AW-1:0] mem_waddr;
  logic [31:0]       mem_wdata;
  logic              mem_re;
  logic [MEM_AW-1:0] mem_raddr;
  logic [31:0]       mem_rdata;
  logic              tx_load;
  logic              tx_active;

  qspi_rx u_qspi_rx (
    .spis_sck_i    (spis_sck_i),
    .rst_i         (rst_i),
    .spis_csb_i    (spis_csb_i),
    .spis_sd_i     (spis_sd_i),
    .quad_en_i     (quad_en),
    .rx_byte_o     (rx_byte),
    .rx_byte_vld_o (rx_byte_vld),
    .rx_word_o     (rx_word)
  );

  qspi_cmd_ctrl u_qspi_cmd_ctrl (
    .spis_sck_i    (spis_sck_i),
    .rst_i         (rst_i),
    .spis_csb_i    (spis_csb_i),
    .rx_byte_i     (rx_byte),
    .rx_byte_vld_i (rx_byte_vld),
    .rx_word_i     (rx_word),
    .quad_en_o     (quad_en),
    .mem_we_o      (mem_we),
    .mem_waddr_o   (mem_waddr),
    .mem_wdata_o   (mem_wdata),
    .mem_re_o      (mem_re),
    .mem_raddr_o   (mem_raddr),
    .tx_load_o     (tx_load),
    .tx_active_o   (tx_active)
  );

  qspi_mem u_qspi_mem (
    .spis_sck_i (spis_sck_i),
    .we_i       (mem_we),
    .waddr_i    (mem_waddr),
    .wdata_i    (mem_wdata),
    .re_i       (mem_re),
    .raddr_i    (mem_raddr),
    .rdata_o    (mem_rdata)
  );

  // Read data goes straight into the serializer
  qspi_tx u_qspi_tx (
    .spis_sck_i (spis_sck_i),
    .rst_i      (rst_i),
    .load_i     (tx_load),
    .word_i     (mem_rdata),
    .active_i   (tx_active),
    .spis_sd_o  (spis_sd_o),
    .spis_oe_o  (spis_oe_o)
  );

  assign quad_en_o = quad_en;

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
//////////////////////////////////////////////////
// Testbench clock and reset
// 20 ns serial clock, reset held for 10 cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/qspi_slave_asserts.sv
//////////////////////////////////////////////////
// QSPI slave protocol assertions
// Output enable and quad mode rules, bound to
// the slave top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qspi_slave_asserts import qspi_pkg::*; (
  input wire logic spis_sck_i,
  input wire logic rst_i,
  input wire logic spis_csb_i,
  input wire logic spis_oe_i,
  input wire logic quad_en_i,
  input wire logic mem_re_i,
  input wire logic tx_active_i
);

  logic                   rst_q;         // Reset seen on the previous edge
  logic                   csb_q;         // Chip select seen on the previous edge
  logic                   first_due_q;   // First data nibble expected now
  logic [DUMMY_CNT_W-1:0] quiet_cnt_q;   // Dummy clocks still to come
  logic                   dummy_start;
  int unsigned            fail_cnt = 0;  // Failed checks, read at the end of the run

  // First fetch of a read frame, issued during the dummy phase
  assign dummy_start = mem_re_i && !tx_active_i;

  always_ff @(posedge spis_sck_i) begin
    rst_q <= rst_i;
    csb_q <= spis_csb_i;
  end

  // Strobe is seen one edge into the dummy phase, so two dummy clocks are gone
  always_ff @(posedge spis_sck_i) begin
    if (rst_i || spis_csb_i) begin
      quiet_cnt_q <= '0;
      first_due_q <= 1'b0;
    end else begin
      first_due_q <= (quiet_cnt_q == DUMMY_CNT_W'(1));  // Last dummy clock
      if (dummy_start) begin
        quiet_cnt_q <= DUMMY_CNT_W'(DUMMY_CYCLES - 2);
      end else if (quiet_cnt_q != '0) begin
        quiet_cnt_q <= quiet_cnt_q - DUMMY_CNT_W'(1);
      end
    end
  end

  a_oe_idle: assert property (@(posedge spis_sck_i) csb_q |-> !spis_oe_i)
    else begin
      $error("output enable still high after chip select went high");
      fail_cnt++;
    end

  a_oe_reset: assert property (@(posedge spis_sck_i) rst_q |-> !spis_oe_i)
    else begin
      $error("output enable high in the cycle after reset");
      fail_cnt++;
    end

  a_quad_reset: assert property (@(posedge spis_sck_i) rst_q |-> !quad_en_i)
    else begin
      $error("quad mode set in the cycle after reset");
      fail_cnt++;
    end

  // Lanes stay released through the whole dummy phase
  a_oe_dummy: assert property (@(posedge spis_sck_i) disable iff (rst_i)
                               (dummy_start || (quiet_cnt_q != '0)) |-> !spis_oe_i)
    else begin
      $error("output enable high during the dummy phase");
      fail_cnt++;
    end

  a_oe_first: assert property (@(posedge spis_sck_i) disable iff (rst_i)
                               first_due_q |-> spis_oe_i)
    else begin
      $error("output enable not high after the last dummy clock");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- testbench/qspi_slave_tb.sv
//////////////////////////////////////////////////
// QSPI memory slave testbench
// Acts as a quad SPI master, loads and reads the
// word memory and compares against a model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module qspi_slave_tb import qspi_pkg::*; ();

  localparam int OE_TIMEOUT = 4 * DUMMY_CYCLES;  // Clocks allowed for read data to start

  logic              spis_sck;
  logic              rst;
  logic              spis_csb;
  logic [3:0]        spis_sd_in;   // Master to slave lanes
  logic [3:0]        spis_sd_out;  // Slave to master lanes
  logic              spis_oe;
  logic              quad_en;
  logic              quad_mode;    // Mode the master believes the slave is in
  int                err_cnt;
  int unsigned       assert_cnt;
  logic [31:0]       ref_mem [logic [MEM_AW-1:0]];  // Expected memory by word index

  tb_clock u_tb_clock (
    .clk_o (spis_sck),
    .rst_o (rst)
  );

  qspi_slave_top u_qspi_slave_top (
    .spis_sck_i (spis_sck),
    .rst_i      (rst),
    .spis_csb_i (spis_csb),
    .spis_sd_i  (spis_sd_in),
    .spis_sd_o  (spis_sd_out),
    .spis_oe_o  (spis_oe),
    .quad_en_o  (quad_en)
  );

  bind qspi_slave_top qspi_slave_asserts u_qspi_slave_asserts (
    .spis_sck_i  (spis_sck_i),
    .rst_i       (rst_i),
    .spis_csb_i  (spis_csb_i),
    .spis_oe_i   (spis_oe_o),
    .quad_en_i   (quad_en_o),
    .mem_re_i    (mem_re),
    .tx_active_i (tx_active)
  );

  // One master clock with chip select held low
  task automatic drive_lanes(input logic [3:0] lanes);
    @(posedge spis_sck);
    spis_csb   <= 1'b0;
    spis_sd_in <= lanes;
  endtask

  // MSB first on lane 0 only or on all four lanes
  task automatic send_byte(input logic [7:0] data);
    if (quad_mode) begin
      drive_lanes(data[7:4]);
      drive_lanes(data[3:0]);
    end else begin
      for (int i = 7; i >= 0; i--) begin
        drive_lanes({3'b000, data[i]});
      end
    end
  endtask

  task automatic send_head(input logic [7:0] cmd, input logic [31:0] addr);
    send_byte(cmd);
    for (int i = ADDR_BYTES - 1; i >= 0; i--) begin
      send_byte(addr[8*i +: 8]);
    end
  endtask

  // Slave samples the last bit on the first edge and acts on the byte on the second
  task automatic end_frame();
    @(posedge spis_sck);
    @(posedge spis_sck);
    spis_csb   <= 1'b1;
    spis_sd_in <= 4'h0;
    repeat (2) @(posedge spis_sck);  // Idle gap between frames
  endtask

  task automatic status_set(input logic quad);
    logic [7:0] status;
    status                  = 8'h00;
    status[STATUS_QUAD_BIT] = quad;
    send_byte(CMD_STATUS);  // Accepted in either mode
    send_byte(status);
    end_frame();
    quad_mode = quad;
    chk_quad: assert (quad_en == quad) else begin
      $display("mismatch quad_en_o: got 0x%h expected 0x%h", quad_en, quad);
      err_cnt++;
    end
  endtask

  // Random words from addr upward
  task automatic write_words(input logic [31:0] addr, input int count);
    logic [31:0]       data;
    logic [MEM_AW-1:0] idx;
    idx = addr[MEM_AW+1:2];
    send_head(CMD_WRITE, addr);
    for (int w = 0; w < count; w++) begin
      data = $urandom();
      for (int i = 3; i >= 0; i--) begin
        send_byte(data[8*i +: 8]);
      end
      if (quad_mode) begin
        ref_mem[idx] = data;  // Single mode writes leave the memory alone
      end
      idx = idx + MEM_AW'(1);  // Wraps onto MEM_WORDS words
    end
    end_frame();
  endtask

  // Reads count words and waits tail more clocks before chip select rises
  task automatic read_words(input logic [31:0] addr, input int count, input int tail);
    logic [MEM_AW-1:0] idx;
    logic [31:0]       got;
    int                lat;
    idx = addr[MEM_AW+1:2];
    send_head(CMD_READ, addr);
    @(posedge spis_sck);  // Slave takes the last address nibble here
    lat = 0;
    do begin
      @(posedge spis_sck);
      lat++;
    end while (!spis_oe && (lat < OE_TIMEOUT));
    if (!quad_mode) begin
      chk_quiet: assert (!spis_oe) else begin
        $display("read command in single mode turned the data lanes around");
        err_cnt++;
      end
    end else if (!spis_oe) begin
      $display("timeout waiting for read data after address 0x%h", addr);
      err_cnt++;
    end else begin
      // Dummy clocks plus the edge that samples nibble 0
      chk_lat: assert (lat == DUMMY_CYCLES + 1) else begin
        $display("mismatch spis_oe_o delay: got 0x%h expected 0x%h", lat, DUMMY_CYCLES + 1);
        err_cnt++;
      end
      for (int w = 0; w < count; w++) begin
        got = '0;
        for (int n = 0; n < 8; n++) begin
          if ((w != 0) || (n != 0)) begin
            @(posedge spis_sck);
          end
          got = {got[27:0], spis_sd_out};
        end
        chk_word: assert (got == ref_mem[idx]) else begin
          $display("mismatch spis_sd_o at index 0x%h: got 0x%h expected 0x%h",
                   idx, got, ref_mem[idx]);
          err_cnt++;
        end
        idx = idx + MEM_AW'(1);
      end
      repeat (tail) @(posedge spis_sck);
    end
    end_frame();
  endtask

  initial begin
    int          wait_cnt;
    logic [31:0] base;
    spis_csb   = 1'b1;
    spis_sd_in = 4'h0;
    quad_mode  = 1'b0;
    err_cnt    = 0;
    wait_cnt   = 0;
    void'($urandom(32'hb2c75320));
    do begin
      @(posedge spis_sck);
      wait_cnt++;
    end while (rst && (wait_cnt < 50));
    if (rst) begin
      $display("timeout waiting for reset release");
      err_cnt++;
    end
    chk_reset_mode: assert (!quad_en) else begin
      $display("mismatch quad_en_o: got 0x%h expected 0x0", quad_en);
      err_cnt++;
    end
    status_set(1'b1);  // Lane 0 status frame
    base = 32'h0000_0100;
    write_words(base, 2);
    status_set(1'b0);  // Quad status frame back to single lane
    write_words(base, 2);  // Dropped
    read_words(base, 2, 0);  // Dropped and the lanes stay released
    status_set(1'b1);
    read_words(base, 2, 0);  // Still the old words
    write_words(32'h0000_0040, 1);
    read_words(32'h0000_0040, 1, 0);
    base = $urandom();  // Burst at a random address
    write_words(base, 6);
    read_words(base, 6, 0);
    write_words(32'h0B00_0000, 1);  // Same word as address 0
    read_words(32'h0000_0000, 1, 0);
    read_words(base, 2, 3);  // Cut off inside the third word
    write_words(32'h0000_0200, 1);
    read_words(32'hFF00_0200, 1, 0);
    repeat (4) @(posedge spis_sck);
    assert_cnt = u_qspi_slave_top.u_qspi_slave_asserts.fail_cnt;
    $display("errors: %0d testbench checks, %0d assertions", err_cnt, assert_cnt);
    if ((err_cnt == 0) && (assert_cnt == 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- qspi_slave_top.f
design/qspi_pkg.sv
design/qspi_rx.sv
design/qspi_cmd_ctrl.sv
design/qspi_mem.sv
design/qspi_tx.sv
design/qspi_slave_top.sv
testbench/tb_clock.sv
testbench/qspi_slave_asserts.sv
testbench/qspi_slave_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the QSPI slave testbench with Verilator, runs it and checks the log

rm -f sim.log &&
verilator --binary --timing --assert --top-module qspi_slave_tb \
  -f qspi_slave_top.f -o qspi_slave_sim &&
./obj_dir/qspi_slave_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && exit 0 || exit 1
